//--- Bender.yml
package:
  name: video_adjust

sources:
  - files:
      - rtl/video_adj_pkg.sv
      - rtl/adj_coef_latch.sv
      - rtl/contrast_brightness.sv
      - rtl/frame_stats.sv
      - rtl/video_adjust_top.sv
  - target: test
    files:
      - bench/tb_video_adjust.sv

//--- bench/tb_video_adjust.sv
/*
  Plays bench/video_adjust_stim.txt into video_adjust_top at 8 bits per channel.
  Run from the project root so the stim path resolves.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_video_adjust;

    import video_adj_pkg::*;

    localparam int PIXEL_WIDTH = 8;
    localparam int PIPE_LAT    = 5;
    localparam int MAX_REC     = 256;

    logic                     clk;
    logic                     reset_i;
    logic                     cfg_wr_i;
    coe_t                     contrast_i;
    bright_t                  brightness_i;
    logic [3*PIXEL_WIDTH-1:0] di_i;
    logic                     de_i;
    logic                     hs_i;
    logic                     vs_i;
    logic [3*PIXEL_WIDTH-1:0] do_o;
    logic                     de_o;
    logic                     hs_o;
    logic                     vs_o;
    pix_count_t               stat_count_o;
    pix_sum_t                 stat_sum_o;
    logic                     stat_valid_o;

    // records as read from the stim file with fields in [0] upwards
    logic [7:0]           rec_code [0:MAX_REC-1];
    logic [8:0][31:0]     rec_val  [0:MAX_REC-1];
    logic [8*24-1:0]      rec_name [0:MAX_REC-1];
    int                   n_rec = 0;

    // expected outputs with one entry per driven cycle
    int                   exp_stamp_q[$];
    logic [2:0]           exp_ctrl_q[$];
    logic [23:0]          exp_pix_q[$];
    int                   exp_count_q[$];
    int                   exp_sum_q[$];
    logic [8*24-1:0]      exp_name_q[$];

    int                   drive_cyc = 0;
    int                   wd_cyc = 0;
    int                   cyc_limit = 0;
    int                   err_count = 0;
    int                   errs_at_last_test = 0;
    int                   tests_ok = 0;
    int                   tests_bad = 0;
    logic [2:0]           ctrl_now;
    logic [23:0]          pix_now;
    logic                 vs_d1 = 1'b0;
    logic                 vs_d2 = 1'b0;
    logic                 valid_exp;

    video_adjust_top #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) UUT (
        .clk          (clk),
        .reset_i      (reset_i),
        .contrast_i   (contrast_i),
        .brightness_i (brightness_i),
        .cfg_wr_i     (cfg_wr_i),
        .di_i         (di_i),
        .de_i         (de_i),
        .hs_i         (hs_i),
        .vs_i         (vs_i),
        .do_o         (do_o),
        .de_o         (de_o),
        .hs_o         (hs_o),
        .vs_o         (vs_o),
        .stat_count_o (stat_count_o),
        .stat_sum_o   (stat_sum_o),
        .stat_valid_o (stat_valid_o)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string sig_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH at %0t: %s expected %0d, got %0d",
                     $time, sig_name, expected, actual);
            err_count++;
        end
    endtask

    // ------------------------------------------------------------------------
    // stim file reader
    // ------------------------------------------------------------------------
    task automatic load_stim();
        int               fd;
        int               n;
        int               f0, f1, f2, f3, f4, f5, f6, f7, f8;
        logic [8*128-1:0] line;
        logic [7:0]       code;
        logic [8*24-1:0]  name;
        fd = $fopen("bench/video_adjust_stim.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the stimulus file");
            err_count++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                code = 8'h00;
                name = '0;
                {f0, f1, f2, f3, f4, f5, f6, f7, f8} = '0;
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, " %c", code);
                end
                // blank lines and comments fall through here
                if (n == 1 && code != "#") begin
                    if (code == "W") begin
                        n = $sscanf(line, " %c %d %d", code, f0, f1);
                    end else if (code == "F") begin
                        n = $sscanf(line, " %c %d %d %s", code, f0, f1, name);
                    end else if (code == "P") begin
                        n = $sscanf(line, " %c %d %d %d %d %d %d %d %d %d",
                                    code, f0, f1, f2, f3, f4, f5, f6, f7, f8);
                    end else begin
                        $display("ERROR: unknown record type in the stimulus file");
                        err_count++;
                    end
                    if (code == "W" || code == "F" || code == "P") begin
                        if (n_rec < MAX_REC) begin
                            rec_code[n_rec] = code;
                            rec_val[n_rec]  = {f8, f7, f6, f5, f4, f3, f2, f1, f0};
                            rec_name[n_rec] = name;
                            n_rec++;
                        end else begin
                            $display("ERROR: too many records in the stimulus file");
                            err_count++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------------------
    // drivers that take one clock each
    // ------------------------------------------------------------------------
    task automatic push_expected(input logic [2:0] ctrl, input logic [23:0] pix);
        exp_stamp_q.push_back(drive_cyc);
        exp_ctrl_q.push_back(ctrl);
        exp_pix_q.push_back(pix);
    endtask

    task automatic drive_idle(input logic push);
        @(posedge clk);
        drive_cyc++;
        cfg_wr_i <= 1'b0;
        di_i     <= '0;
        de_i     <= 1'b0;
        hs_i     <= 1'b0;
        vs_i     <= 1'b0;
        if (push) begin
            push_expected(3'b000, '0);
        end
    endtask

    task automatic write_settings(input int coe, input int bri);
        drive_idle(1'b1);
        cfg_wr_i     <= 1'b1;
        contrast_i   <= coe_t'(coe);
        brightness_i <= bright_t'(bri);
    endtask

    task automatic drive_pixel(input logic [8:0][31:0] fld);
        @(posedge clk);
        drive_cyc++;
        cfg_wr_i <= 1'b0;
        di_i     <= {fld[2][7:0], fld[1][7:0], fld[0][7:0]};
        de_i     <= fld[3][0];
        hs_i     <= fld[4][0];
        vs_i     <= fld[5][0];
        push_expected({fld[3][0], fld[4][0], fld[5][0]},
                      {fld[8][7:0], fld[7][7:0], fld[6][7:0]});
    endtask

    // one test ends with the statistics of its frame
    task automatic close_test();
        int errs;
        if (exp_count_q.size() == 0) begin
            $display("ERROR: statistics pulse arrived with no frame left to check");
            err_count++;
        end else begin
            check_value("stat_count_o", exp_count_q.pop_front(), 32'(stat_count_o));
            check_value("stat_sum_o", exp_sum_q.pop_front(), stat_sum_o);
            errs = err_count - errs_at_last_test;
            errs_at_last_test = err_count;
            if (errs == 0) begin
                tests_ok++;
            end else begin
                tests_bad++;
            end
            $display("test %0s: %s, %0d errors", exp_name_q.pop_front(),
                     (errs == 0) ? "ok" : "FAIL", errs);
        end
    endtask

    // ------------------------------------------------------------------------
    // output checker sampling on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (exp_stamp_q.size() > 0 && exp_stamp_q[0] + PIPE_LAT == drive_cyc) begin
            void'(exp_stamp_q.pop_front());
            ctrl_now = exp_ctrl_q.pop_front();
            pix_now  = exp_pix_q.pop_front();
            check_value("de_o", ctrl_now[2], de_o);
            check_value("hs_o", ctrl_now[1], hs_o);
            check_value("vs_o", ctrl_now[0], vs_o);
            if (ctrl_now[2]) begin
                check_value("do_o.r", pix_now[7:0], do_o[7:0]);
                check_value("do_o.g", pix_now[15:8], do_o[15:8]);
                check_value("do_o.b", pix_now[23:16], do_o[23:16]);
            end
            // pulse follows the output VSYNC rising edge by one cycle
            valid_exp = vs_d1 & ~vs_d2;
            check_value("stat_valid_o", valid_exp, stat_valid_o);
            if (valid_exp) begin
                close_test();
            end
            vs_d2 = vs_d1;
            vs_d1 = ctrl_now[0];
        end
    end

    always @(posedge clk) begin
        wd_cyc++;
        if (cyc_limit > 0 && wd_cyc > cyc_limit) begin
            $display("ERROR: the run timed out before all records were checked");
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        reset_i      = 1'b1;
        cfg_wr_i     = 1'b0;
        contrast_i   = COE_ONE;
        brightness_i = '0;
        di_i         = '0;
        de_i         = 1'b0;
        hs_i         = 1'b0;
        vs_i         = 1'b0;
        void'($urandom(32'hf07f_f2b1));
        load_stim();
        cyc_limit = 2 * n_rec + 200;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        for (int i = 0; i < n_rec; i++) begin
            if (rec_code[i] == "W") begin
                write_settings(int'(rec_val[i][0]), int'(rec_val[i][1]));
            end else if (rec_code[i] == "F") begin
                exp_count_q.push_back(rec_val[i][0]);
                exp_sum_q.push_back(rec_val[i][1]);
                exp_name_q.push_back(rec_name[i]);
            end else begin
                // random blanking before each line start
                if (rec_val[i][4] == 1 && rec_val[i][5] == 0) begin
                    repeat ($urandom % 4) drive_idle(1'b1);
                end
                drive_pixel(rec_val[i]);
            end
        end
        repeat (4) drive_idle(1'b1);
        repeat (PIPE_LAT + 1) drive_idle(1'b0);
        if (exp_stamp_q.size() != 0 || exp_count_q.size() != 0) begin
            $display("ERROR: some expected outputs were never checked");
            err_count++;
        end
        $display("summary: %0d tests ok, %0d tests with errors, %0d errors in total",
                 tests_ok, tests_bad, err_count);
        if (err_count == 0 && tests_bad == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/video_adjust_stim.txt
# W contrast brightness | P r g b de hs vs exp_r exp_g exp_b (exp checked when de=1)
# F count sum name: expected statistics of the frame just sent, closes one test
F 0 0 startup
# identity after reset
P 0 0 0 0 0 1 0 0 0
P 0 0 0 0 1 0 0 0 0
P 10 20 30 1 0 0 10 20 30
P 200 128 255 1 0 0 200 128 255
P 0 0 0 0 1 0 0 0 0
P 0 1 127 1 0 0 0 1 127
F 3 771 identity
W 96 20
P 0 0 0 0 0 1 0 0 0
P 0 0 0 0 1 0 0 0 0
P 128 129 127 1 0 0 148 150 147
P 130 100 170 1 0 0 151 106 211
F 2 913 gain_96
W 32 -15
P 0 0 0 0 0 1 0 0 0
P 0 0 0 0 1 0 0 0 0
P 0 255 129 1 0 0 49 177 114
P 127 60 131 1 0 0 113 79 115
F 2 647 gain_32
# gain 5.0 with +100 saturates both ways
W 320 100
P 0 0 0 0 0 1 0 0 0
P 0 0 0 0 1 0 0 0 0
P 140 128 100 1 0 0 255 228 88
P 0 255 130 1 0 0 0 255 238
F 2 1064 clamp
W 64 -128
P 0 0 0 0 0 1 0 0 0
P 0 0 0 0 1 0 0 0 0
P 50 200 127 1 0 0 0 72 0
W 96 20
P 130 100 255 1 0 0 2 0 127
F 2 201 mid_frame_write
P 0 0 0 0 0 1 0 0 0
P 0 0 0 0 1 0 0 0 0
P 129 130 128 1 0 0 150 151 148
F 1 449 new_frame
P 0 0 0 0 0 1 0 0 0

//--- rtl/adj_coef_latch.sv
/*
  Settings written on cfg_wr_i stay pending until the next VSYNC rising edge.
  A write on the edge cycle itself is applied straight away.
*/
`timescale 1ns/1ps
`default_nettype none

module adj_coef_latch (
    input  wire                      clk,
    input  wire                      reset_i,

    // host side
    input  wire                      cfg_wr_i,
    input  wire video_adj_pkg::coe_t    contrast_i,
    input  wire video_adj_pkg::bright_t brightness_i,

    // frame timing
    input  wire                      vs_i,

    // applied settings
    output video_adj_pkg::coe_t      contrast_o,
    output video_adj_pkg::bright_t   brightness_o
);

    import video_adj_pkg::*;

    coe_t    pend_contrast;
    bright_t pend_brightness;
    logic    vs_q;
    logic    vs_rise;

    // ------------------------------------------------------------------------
    // frame start detect
    // ------------------------------------------------------------------------
    assign vs_rise = vs_i & ~vs_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vs_q <= 1'b0;
        end else begin
            vs_q <= vs_i;
        end
    end

    // ------------------------------------------------------------------------
    // pending copy, follows every host write
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pend_contrast   <= COE_ONE;
            pend_brightness <= '0;
        end else if (cfg_wr_i) begin
            pend_contrast   <= contrast_i;
            pend_brightness <= brightness_i;
        end
    end

    // ------------------------------------------------------------------------
    // applied copy, only moves at a frame boundary
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            contrast_o   <= COE_ONE;
            brightness_o <= '0;
        end else if (vs_rise) begin
            // bypass the pending copy when the write lands on the edge
            contrast_o   <= cfg_wr_i ? contrast_i : pend_contrast;
            brightness_o <= cfg_wr_i ? brightness_i : pend_brightness;
        end
    end

endmodule

`default_nettype wire

//--- rtl/contrast_brightness.sv
/*
  out = floor((c*(in-mid) + 32)/64) + mid + b, clamped to 0..2^PIXEL_WIDTH-1.
  PIXEL_WIDTH is 8 or 10; at 10 the brightness is scaled by 4. Latency is 5.
*/
`timescale 1ns/1ps
`default_nettype none

module contrast_brightness #(
    parameter int PIXEL_WIDTH = 8
) (
    input  wire                         clk,
    input  wire                         reset_i,

    // settings, sampled with the pixel
    input  wire video_adj_pkg::coe_t    contrast_i,
    input  wire video_adj_pkg::bright_t brightness_i,

    // R in the low slice, then G, then B
    input  wire [3*PIXEL_WIDTH-1:0]     di_i,
    input  wire                         de_i,
    input  wire                         hs_i,
    input  wire                         vs_i,

    output logic [3*PIXEL_WIDTH-1:0]    do_o,
    output logic                        de_o,
    output logic                        hs_o,
    output logic                        vs_o
);

    import video_adj_pkg::*;

    // product of coefficient and pixel, unsigned
    localparam int PROD_W = COE_WIDTH + PIXEL_WIDTH;
    // signed accumulator, sign bit plus one guard bit over the product
    localparam int ACC_W  = PROD_W + 2;
    // first bit above the integer pixel range
    localparam int OVF_BIT = COE_FRAC + PIXEL_WIDTH;
    localparam int BRIGHT_SHIFT = PIXEL_WIDTH - 8;
    localparam int MID = 1 << (PIXEL_WIDTH - 1);

    typedef logic        [PROD_W-1:0] prod_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    localparam acc_t MID_ACC   = acc_t'(MID);
    localparam acc_t ROUND_ACC = acc_t'(ROUND_HALF);

    // ------------------------------------------------------------------------
    // terms shared by the three channels
    // ------------------------------------------------------------------------
    prod_t pivot_c;
    acc_t  bright_ext;
    acc_t  offset_c;

    prod_t pivot_q;
    acc_t  offset_q;
    acc_t  offset_d1;

    // gain applied to mid-grey, i.e. contrast << (PIXEL_WIDTH-1)
    assign pivot_c = prod_t'(contrast_i) << (PIXEL_WIDTH - 1);

    assign bright_ext = acc_t'(signed'(brightness_i));

    // (mid + brightness) moved up into the Q.6 domain
    assign offset_c = (MID_ACC + (bright_ext <<< BRIGHT_SHIFT)) <<< COE_FRAC;

    always_ff @(posedge clk) begin
        // stage 0
        pivot_q   <= pivot_c;
        offset_q  <= offset_c;
        // stage 1, keeps the offset in step with the difference
        offset_d1 <= offset_q;
    end

    // ------------------------------------------------------------------------
    // per-channel datapath
    // ------------------------------------------------------------------------
    genvar ch;
    generate
        for (ch = 0; ch < 3; ch++) begin : g_chan
            logic [PIXEL_WIDTH-1:0] pix_in;
            prod_t                  prod_q;
            acc_t                   diff_q;
            acc_t                   sum_q;
            acc_t                   rnd_q;
            logic [PIXEL_WIDTH-1:0] pix_q;

            assign pix_in = di_i[ch*PIXEL_WIDTH +: PIXEL_WIDTH];

            always_ff @(posedge clk) begin
                // stage 0, gain
                prod_q <= contrast_i * pix_in;
                // stage 1, remove the pivot
                diff_q <= acc_t'(prod_q) - acc_t'(pivot_q);
                // stage 2, back to mid plus brightness
                sum_q  <= diff_q + offset_d1;
                // stage 3, half LSB for round half up
                rnd_q  <= sum_q + ROUND_ACC;
            end

            // stage 4, clamp and drop the fraction
            always_ff @(posedge clk) begin
                if (reset_i) begin
                    pix_q <= '0;
                end else if (rnd_q[ACC_W-1]) begin
                    pix_q <= '0;
                end else if (|rnd_q[ACC_W-2:OVF_BIT]) begin
                    pix_q <= '1;
                end else begin
                    pix_q <= rnd_q[COE_FRAC +: PIXEL_WIDTH];
                end
            end

            assign do_o[ch*PIXEL_WIDTH +: PIXEL_WIDTH] = pix_q;
        end
    endgenerate

    // ------------------------------------------------------------------------
    // sync and DE delay, 4 deep plus the output register
    // ------------------------------------------------------------------------
    logic [3:0] de_sr;
    logic [3:0] hs_sr;
    logic [3:0] vs_sr;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_sr <= '0;
            hs_sr <= '0;
            vs_sr <= '0;
            de_o  <= 1'b0;
            hs_o  <= 1'b0;
            vs_o  <= 1'b0;
        end else begin
            de_sr <= {de_sr[2:0], de_i};
            hs_sr <= {hs_sr[2:0], hs_i};
            vs_sr <= {vs_sr[2:0], vs_i};
            de_o  <= de_sr[3];
            hs_o  <= hs_sr[3];
            vs_o  <= vs_sr[3];
        end
    end

endmodule

`default_nettype wire

//--- rtl/frame_stats.sv
/*
  Active pixel count and R+G+B sum per frame, reported one cycle after
  each VSYNC rising edge. Totals wrap silently beyond the type widths.
*/
`timescale 1ns/1ps
`default_nettype none

module frame_stats #(
    parameter int PIXEL_WIDTH = 8
) (
    input  wire                         clk,
    input  wire                         reset_i,

    // pipeline output stream
    input  wire [3*PIXEL_WIDTH-1:0]     do_i,
    input  wire                         de_i,
    input  wire                         vs_i,

    output video_adj_pkg::pix_count_t   stat_count_o,
    output video_adj_pkg::pix_sum_t     stat_sum_o,
    output logic                        stat_valid_o
);

    import video_adj_pkg::*;

    logic [PIXEL_WIDTH+1:0] chan_sum;
    pix_count_t             count_q;
    pix_sum_t               sum_q;
    logic                   vs_q;
    logic                   vs_rise;

    assign chan_sum = (PIXEL_WIDTH + 2)'(do_i[0*PIXEL_WIDTH +: PIXEL_WIDTH])
                    + (PIXEL_WIDTH + 2)'(do_i[1*PIXEL_WIDTH +: PIXEL_WIDTH])
                    + (PIXEL_WIDTH + 2)'(do_i[2*PIXEL_WIDTH +: PIXEL_WIDTH]);

    assign vs_rise = vs_i & ~vs_q;

    // ------------------------------------------------------------------------
    // running totals
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            vs_q    <= 1'b0;
            count_q <= '0;
            sum_q   <= '0;
        end else begin
            vs_q <= vs_i;
            if (vs_rise) begin
                // a pixel on the edge cycle opens the new frame
                count_q <= de_i ? pix_count_t'(1) : '0;
                sum_q   <= de_i ? pix_sum_t'(chan_sum) : '0;
            end else if (de_i) begin
                count_q <= count_q + pix_count_t'(1);
                sum_q   <= sum_q + pix_sum_t'(chan_sum);
            end
        end
    end

    // ------------------------------------------------------------------------
    // report at frame start
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            stat_count_o <= '0;
            stat_sum_o   <= '0;
            stat_valid_o <= 1'b0;
        end else begin
            stat_valid_o <= vs_rise;
            if (vs_rise) begin
                stat_count_o <= count_q;
                stat_sum_o   <= sum_q;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/video_adj_pkg.sv
/*
  Shared widths and fixed-point constants for the pixel adjustment path.
  Contrast is unsigned Q5.6, brightness is a signed 8-bit offset.
*/
`default_nettype none

package video_adj_pkg;

    // ------------------------------------------------------------------------
    // contrast coefficient, unsigned Q5.6
    // ------------------------------------------------------------------------
    localparam int COE_WIDTH = 11;
    localparam int COE_FRAC  = 6;

    typedef logic [COE_WIDTH-1:0] coe_t;

    // gain of 1.0, used as the reset value
    localparam coe_t COE_ONE = coe_t'(1 << COE_FRAC);

    // half an output LSB in coefficient fraction units
    localparam int ROUND_HALF = 1 << (COE_FRAC - 1);

    // ------------------------------------------------------------------------
    // brightness offset, signed, 8-bit pixel units
    // ------------------------------------------------------------------------
    localparam int BRIGHT_WIDTH = 8;

    typedef logic [BRIGHT_WIDTH-1:0] bright_t;

    // ------------------------------------------------------------------------
    // per-frame statistics
    // ------------------------------------------------------------------------
    localparam int COUNT_WIDTH = 22;
    localparam int SUM_WIDTH   = 32;

    // enough for 4 Mpixel frames
    typedef logic [COUNT_WIDTH-1:0] pix_count_t;
    typedef logic [SUM_WIDTH-1:0]   pix_sum_t;

endpackage

`default_nettype wire

//--- rtl/video_adjust_top.sv
/*
  Contrast and brightness adjust for an RGB stream, one pixel per clock,
  no back-pressure. PIXEL_WIDTH is 8 or 10; outputs lag inputs by 5 cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module video_adjust_top #(
    parameter int PIXEL_WIDTH = 8
) (
    input  wire                         clk,
    input  wire                         reset_i,

    // host settings
    input  wire video_adj_pkg::coe_t    contrast_i,
    input  wire video_adj_pkg::bright_t brightness_i,
    input  wire                         cfg_wr_i,

    // video in
    input  wire [3*PIXEL_WIDTH-1:0]     di_i,
    input  wire                         de_i,
    input  wire                         hs_i,
    input  wire                         vs_i,

    // video out
    output logic [3*PIXEL_WIDTH-1:0]    do_o,
    output logic                        de_o,
    output logic                        hs_o,
    output logic                        vs_o,

    // per-frame statistics
    output video_adj_pkg::pix_count_t   stat_count_o,
    output video_adj_pkg::pix_sum_t     stat_sum_o,
    output logic                        stat_valid_o
);

    import video_adj_pkg::*;

    // settings in force for the current frame
    coe_t    contrast_act;
    bright_t brightness_act;

    // ------------------------------------------------------------------------
    // input side
    // ------------------------------------------------------------------------
    adj_coef_latch u_coef_latch (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_wr_i     (cfg_wr_i),
        .contrast_i   (contrast_i),
        .brightness_i (brightness_i),
        .vs_i         (vs_i),
        .contrast_o   (contrast_act),
        .brightness_o (brightness_act)
    );

    // ------------------------------------------------------------------------
    // pixel pipeline
    // ------------------------------------------------------------------------
    contrast_brightness #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) u_adjust (
        .clk          (clk),
        .reset_i      (reset_i),
        .contrast_i   (contrast_act),
        .brightness_i (brightness_act),
        .di_i         (di_i),
        .de_i         (de_i),
        .hs_i         (hs_i),
        .vs_i         (vs_i),
        .do_o         (do_o),
        .de_o         (de_o),
        .hs_o         (hs_o),
        .vs_o         (vs_o)
    );

    // ------------------------------------------------------------------------
    // output side, measures what leaves the pipeline
    // ------------------------------------------------------------------------
    frame_stats #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) u_stats (
        .clk          (clk),
        .reset_i      (reset_i),
        .do_i         (do_o),
        .de_i         (de_o),
        .vs_i         (vs_o),
        .stat_count_o (stat_count_o),
        .stat_sum_o   (stat_sum_o),
        .stat_valid_o (stat_valid_o)
    );

endmodule

`default_nettype wire

//--- sources.f
rtl/video_adj_pkg.sv
rtl/adj_coef_latch.sv
rtl/contrast_brightness.sv
rtl/frame_stats.sv
rtl/video_adjust_top.sv
bench/tb_video_adjust.sv
